// File: logic/fabIpPkg.sv
// Shared bus types, address map and constants; imported by every fabric peripheral module
package fabIpPkg;

    // --------------------------------------------------
    // Basic widths and bus field types
    // --------------------------------------------------
    localparam int AdrWidth = 17;

    typedef logic [31:0]         wordT;
    typedef logic [AdrWidth-1:0] adrT;
    typedef logic [3:0]          selT;
    typedef logic [7:0]          gpioT;

    // Master request, one transfer at a time
    typedef struct packed {
        adrT  adr;
        selT  sel;
        logic we;
        logic cyc;
        logic stb;
        wordT dat;
    } wbReqT;

    // Slave response
    typedef struct packed {
        wordT dat;
        logic ack;
    } wbRspT;

    // Decoded region of the 128 KB aperture
    typedef enum logic [1:0] {
        RegionReg,
        RegionRam,
        RegionReserved,
        RegionNone
    } regionE;

    // Register word offsets, address bits 8:2
    typedef enum logic [6:0] {
        RegId      = 7'd0,
        RegRev     = 7'd1,
        RegGpioIn  = 7'd2,
        RegGpioOut = 7'd3,
        RegGpioOe  = 7'd4
    } regAddrE;

    // --------------------------------------------------
    // Address map
    // --------------------------------------------------
    // Region field is address bits 16:12
    localparam int  RegionLsb    = 12;
    localparam adrT RegBase      = 17'h00000;
    localparam adrT RamBase      = 17'h01000;
    localparam adrT ReservedBase = 17'h08000;

    // Reserved block word offsets
    localparam logic [6:0] ResCustProdAdr  = 7'h7E;
    localparam logic [6:0] ResRevisionsAdr = 7'h7F;

    // --------------------------------------------------
    // Identification and default read values
    // --------------------------------------------------
    localparam wordT DeviceIdValue  = 32'h0000_5A3B;
    localparam wordT RevLevel       = 32'h0000_0100;
    localparam wordT CustProdValue  = 32'h0000_0100;
    localparam wordT RevisionsValue = 32'h0001_0000;

    // Distinct patterns per kind of miss
    localparam wordT RegDefault = 32'hFAB_DEF_AC;
    localparam wordT ResDefault = 32'hDEF_FAB_AC;
    localparam wordT BadAccess  = 32'hBAD_FAB_AC;

    // Scratch RAM geometry
    localparam int RamDepth    = 256;
    localparam int RamAdrWidth = 8;

    // Watchdog for unclaimed cycles
    localparam int                     WatchdogWidth   = 3;
    localparam logic [WatchdogWidth-1:0] WatchdogTimeout = 3'd7;

endpackage

// File: logic/fabRegisters.sv
// Register block with ID, revision and GPIO registers; sits in the register region of the fabric
`timescale 1ns/1ps

module fabRegisters
    import fabIpPkg::*;
(
    input  logic  wbClk_i,
    input  logic  rstN_i,
    input  wbReqT req_i,
    output wbRspT rsp_o,
    input  gpioT  gpioIn_i,
    output gpioT  gpioOut_o,
    output gpioT  gpioOe_o
);

    // --------------------------------------------------
    // Request qualification
    // --------------------------------------------------
    logic    reqValid;
    logic    reqSeenQ;
    logic    accept;
    logic    ackQ;
    regAddrE regAddr;
    wordT    rdDatQ;
    gpioT    gpioOutQ;
    gpioT    gpioOeQ;

    assign reqValid = req_i.cyc & req_i.stb;
    // Only the first sampled edge of a request is taken
    assign accept   = reqValid & ~reqSeenQ & ~ackQ;
    // Word offset within the region
    assign regAddr  = regAddrE'(req_i.adr[8:2]);

    // --------------------------------------------------
    // Control state and GPIO registers
    // --------------------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            ackQ     <= 1'b0;
            reqSeenQ <= 1'b0;
            gpioOutQ <= '0;
            gpioOeQ  <= '0;
        end
        else
        begin
            ackQ     <= accept;
            reqSeenQ <= reqValid;
            // GPIO writes use byte lane 0 only
            if (accept && req_i.we && req_i.sel[0])
            begin
                if (regAddr == RegGpioOut)
                    gpioOutQ <= req_i.dat[$bits(gpioT)-1:0];
                if (regAddr == RegGpioOe)
                    gpioOeQ <= req_i.dat[$bits(gpioT)-1:0];
            end
        end
    end

    // Read word captured with the ack
    always_ff @(posedge wbClk_i)
    begin
        if (accept && !req_i.we)
        begin
            case (regAddr)
                RegId:      rdDatQ <= DeviceIdValue;
                RegRev:     rdDatQ <= RevLevel;
                RegGpioIn:  rdDatQ <= wordT'(gpioIn_i);
                RegGpioOut: rdDatQ <= wordT'(gpioOutQ);
                RegGpioOe:  rdDatQ <= wordT'(gpioOeQ);
                default:    rdDatQ <= RegDefault;
            endcase
        end
    end

    assign rsp_o.dat = rdDatQ;
    assign rsp_o.ack = ackQ;
    assign gpioOut_o = gpioOutQ;
    assign gpioOe_o  = gpioOeQ;

endmodule

// File: logic/fabRam.sv
// Single-port scratch RAM with byte-lane writes; sits in the RAM region of the fabric
`timescale 1ns/1ps

module fabRam
    import fabIpPkg::*;
(
    input  logic  wbClk_i,
    input  logic  rstN_i,
    input  wbReqT req_i,
    output wbRspT rsp_o
);

    wordT                   mem [RamDepth];
    logic [RamAdrWidth-1:0] ramIdx;
    logic                   inRange;
    logic                   reqValid;
    logic                   reqSeenQ;
    logic                   accept;
    logic                   ackQ;
    wordT                   rdDatQ;

    // Word index from bits 9:2
    assign ramIdx   = req_i.adr[RamAdrWidth+1:2];
    // Bits 11:10 above the 256 words must be clear
    assign inRange  = (req_i.adr[RegionLsb-1:RamAdrWidth+2] == '0);
    assign reqValid = req_i.cyc & req_i.stb;
    assign accept   = reqValid & ~reqSeenQ & ~ackQ;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            ackQ     <= 1'b0;
            reqSeenQ <= 1'b0;
        end
        else
        begin
            ackQ     <= accept;
            reqSeenQ <= reqValid;
        end
    end

    // --------------------------------------------------
    // Storage and read port
    // --------------------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (accept && req_i.we && inRange)
        begin
            // Per-lane update
            for (int lane = 0; lane < 4; lane++)
            begin
                if (req_i.sel[lane])
                    mem[ramIdx][8*lane +: 8] <= req_i.dat[8*lane +: 8];
            end
        end
        if (accept && !req_i.we)
            rdDatQ <= inRange ? mem[ramIdx] : RegDefault;
    end

    assign rsp_o.dat = rdDatQ;
    assign rsp_o.ack = ackQ;

endmodule

// File: logic/fabReserved.sv
// Reserved identification words and the bus watchdog that ends any unclaimed cycle
`timescale 1ns/1ps

module fabReserved
    import fabIpPkg::*;
(
    input  logic  wbClk_i,
    input  logic  rstN_i,
    input  wbReqT req_i,
    input  wbReqT busReq_i,
    input  logic  combAck_i,
    output wbRspT rsp_o
);

    logic                     reqValid;
    logic                     reqSeenQ;
    logic                     accept;
    logic                     resAckQ;
    logic [6:0]               resAdr;
    wordT                     rdDatQ;
    logic                     busActive;
    logic [WatchdogWidth-1:0] wdCntQ;
    logic                     wdAckQ;
    logic                     wdDoneQ;

    // --------------------------------------------------
    // Identification words
    // --------------------------------------------------
    assign reqValid = req_i.cyc & req_i.stb;
    assign accept   = reqValid & ~reqSeenQ & ~resAckQ;
    assign resAdr   = req_i.adr[8:2];

    // Writes land here but change nothing
    always_ff @(posedge wbClk_i)
    begin
        if (accept && !req_i.we)
        begin
            case (resAdr)
                ResCustProdAdr:  rdDatQ <= CustProdValue;
                ResRevisionsAdr: rdDatQ <= RevisionsValue;
                default:         rdDatQ <= ResDefault;
            endcase
        end
    end

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    // Ungated master strobe, region is not looked at
    assign busActive = busReq_i.cyc & busReq_i.stb;

    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            resAckQ  <= 1'b0;
            reqSeenQ <= 1'b0;
            wdCntQ   <= '0;
            wdAckQ   <= 1'b0;
            wdDoneQ  <= 1'b0;
        end
        else
        begin
            resAckQ  <= accept;
            reqSeenQ <= reqValid;
            wdAckQ   <= 1'b0;
            // Held after an ack until the master drops stb
            wdDoneQ  <= busActive & (wdDoneQ | combAck_i);
            if (!busActive || combAck_i || wdDoneQ)
                wdCntQ <= '0;
            else if (wdCntQ == WatchdogTimeout)
            begin
                // Nobody answered, end the cycle
                wdAckQ <= 1'b1;
                wdCntQ <= '0;
            end
            else
                wdCntQ <= wdCntQ + 1'b1;
        end
    end

    // Data is ignored by the fabric on a watchdog ack
    assign rsp_o.dat = rdDatQ;
    assign rsp_o.ack = resAckQ | wdAckQ;

endmodule

// File: logic/fabBusFabric.sv
// Region decoder and response mux between the Wishbone port and the three fabric blocks
`timescale 1ns/1ps

module fabBusFabric
    import fabIpPkg::*;
(
    input  wbReqT wbReq_i,
    output wbRspT wbRsp_o,
    output wbReqT regReq_o,
    output wbReqT ramReq_o,
    output wbReqT resReq_o,
    input  wbRspT regRsp_i,
    input  wbRspT ramRsp_i,
    input  wbRspT resRsp_i,
    output logic  combAck_o
);

    logic [AdrWidth-RegionLsb-1:0] regionField;
    regionE                        region;
    logic                          anyAck;

    // --------------------------------------------------
    // Region decode, bits 16:12
    // --------------------------------------------------
    assign regionField = wbReq_i.adr[AdrWidth-1:RegionLsb];

    always_comb
    begin
        case (regionField)
            RegBase[AdrWidth-1:RegionLsb]:      region = RegionReg;
            RamBase[AdrWidth-1:RegionLsb]:      region = RegionRam;
            ReservedBase[AdrWidth-1:RegionLsb]: region = RegionReserved;
            default:                            region = RegionNone;
        endcase
    end

    // Same request everywhere, cyc only where the region hits
    always_comb
    begin
        regReq_o     = wbReq_i;
        ramReq_o     = wbReq_i;
        resReq_o     = wbReq_i;
        regReq_o.cyc = wbReq_i.cyc & (region == RegionReg);
        ramReq_o.cyc = wbReq_i.cyc & (region == RegionRam);
        resReq_o.cyc = wbReq_i.cyc & (region == RegionReserved);
    end

    // --------------------------------------------------
    // Response combine
    // --------------------------------------------------
    // Watchdog ack arrives through the reserved block
    assign anyAck    = regRsp_i.ack | ramRsp_i.ack | resRsp_i.ack;
    assign combAck_o = anyAck;

    always_comb
    begin
        wbRsp_o.ack = anyAck;
        case (region)
            RegionReg:      wbRsp_o.dat = regRsp_i.dat;
            RegionRam:      wbRsp_o.dat = ramRsp_i.dat;
            RegionReserved: wbRsp_o.dat = resRsp_i.dat;
            default:        wbRsp_o.dat = BadAccess;
        endcase
    end

endmodule

// File: logic/fabIpTop.sv
// Top level of the fabric peripheral; connect a Wishbone classic master and the GPIO pins here
`timescale 1ns/1ps

module fabIpTop
    import fabIpPkg::*;
(
    input  logic  wbClk_i,
    input  logic  rstN_i,
    input  wbReqT wbReq_i,
    output wbRspT wbRsp_o,
    input  gpioT  gpioIn_i,
    output gpioT  gpioOut_o,
    output gpioT  gpioOe_o
);

    // Gated requests toward each block
    wbReqT regReq;
    wbReqT ramReq;
    wbReqT resReq;
    // Block responses
    wbRspT regRsp;
    wbRspT ramRsp;
    wbRspT resRsp;
    // Ack of all blocks, feeds the watchdog
    logic  combAck;

    // --------------------------------------------------
    // Decode and response mux
    // --------------------------------------------------
    fabBusFabric fabBusFabric_i (
        .wbReq_i   (wbReq_i),
        .wbRsp_o   (wbRsp_o),
        .regReq_o  (regReq),
        .ramReq_o  (ramReq),
        .resReq_o  (resReq),
        .regRsp_i  (regRsp),
        .ramRsp_i  (ramRsp),
        .resRsp_i  (resRsp),
        .combAck_o (combAck)
    );

    // --------------------------------------------------
    // Blocks
    // --------------------------------------------------
    fabRegisters fabRegisters_i (
        .wbClk_i   (wbClk_i),
        .rstN_i    (rstN_i),
        .req_i     (regReq),
        .rsp_o     (regRsp),
        .gpioIn_i  (gpioIn_i),
        .gpioOut_o (gpioOut_o),
        .gpioOe_o  (gpioOe_o)
    );

    fabRam fabRam_i (
        .wbClk_i (wbClk_i),
        .rstN_i  (rstN_i),
        .req_i   (ramReq),
        .rsp_o   (ramRsp)
    );

    // Watchdog sees the ungated master request
    fabReserved fabReserved_i (
        .wbClk_i   (wbClk_i),
        .rstN_i    (rstN_i),
        .req_i     (resReq),
        .busReq_i  (wbReq_i),
        .combAck_i (combAck),
        .rsp_o     (resRsp)
    );

endmodule

// File: bench/tbClock.sv
// Bench clock and reset source; instantiate once in the testbench top
`timescale 1ns/1ps

module tbClock
(
    output logic clk_o,
    output logic rstN_o
);

    // 4 ns period
    initial
    begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Low for two rising edges, released on a falling edge
    initial
    begin
        rstN_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rstN_o = 1'b1;
    end

endmodule

// File: bench/fabIp_chk.sv
// Wishbone protocol assertions for the fabric top level; attached to fabIpTop by bind
`timescale 1ns/1ps

module fabIpChk
    import fabIpPkg::*;
(
    input logic  wbClk_i,
    input logic  rstN_i,
    input wbReqT wbReq_i,
    input wbRspT wbRsp_i
);

    logic                          reqValid;
    logic                          unmapped;
    logic [AdrWidth-RegionLsb-1:0] regionField;
    // Count of failed assertions
    int                            assertFails = 0;

    assign reqValid    = wbReq_i.cyc & wbReq_i.stb;
    assign regionField = wbReq_i.adr[AdrWidth-1:RegionLsb];
    // None of the three regions
    assign unmapped    = (regionField != RegBase[AdrWidth-1:RegionLsb]) &&
                         (regionField != RamBase[AdrWidth-1:RegionLsb]) &&
                         (regionField != ReservedBase[AdrWidth-1:RegionLsb]);

    ackNeedsReq: assert property (@(posedge wbClk_i) disable iff (!rstN_i)
        wbRsp_i.ack |-> reqValid)
    else
    begin
        $error("ack seen without cyc and stb");
        assertFails++;
    end

    ackSingle: assert property (@(posedge wbClk_i) disable iff (!rstN_i)
        wbRsp_i.ack |=> !wbRsp_i.ack)
    else
    begin
        $error("ack high for two cycles");
        assertFails++;
    end

    ackResetLow: assert property (@(posedge wbClk_i)
        !rstN_i |=> !wbRsp_i.ack)
    else
    begin
        $error("ack high during reset");
        assertFails++;
    end

    // Watchdog answer after WatchdogTimeout + 1 edges
    unmappedLatency: assert property (@(posedge wbClk_i) disable iff (!rstN_i)
        $rose(reqValid) && unmapped |-> !wbRsp_i.ack [*8] ##1 wbRsp_i.ack)
    else
    begin
        $error("unmapped access not acked after 8 cycles");
        assertFails++;
    end

endmodule

bind fabIpTop fabIpChk fabIpChk_i (
    .wbClk_i (wbClk_i),
    .rstN_i  (rstN_i),
    .wbReq_i (wbReq_i),
    .wbRsp_i (wbRsp_o)
);

// File: bench/fabIpTb.sv
// Testbench top for the fabric peripheral; runs directed and random Wishbone traffic against a model
`timescale 1ns/1ps

module fabIpTb
    import fabIpPkg::*;
();

    // Access count over all tests sets the run limit
    localparam int RamOps      = 40;
    localparam int NumAccesses = 4 + 7 + 3 * RamOps + 3 + 1;
    localparam int CycleLimit  = NumAccesses * 10 + 100;

    // Finished access for the compare process
    typedef struct packed {
        adrT         adr;
        logic        we;
        wordT        dat;
        logic [15:0] lat;
    } accessT;

    logic   wbClk;
    logic   rstN;
    wbReqT  wbReq;
    wbRspT  wbRsp;
    gpioT   gpioIn;
    gpioT   gpioOut;
    gpioT   gpioOe;

    // Model state
    wordT                   ramShadow [RamDepth];
    gpioT                   gpioOutShadow = '0;
    gpioT                   gpioOeShadow  = '0;
    logic [RamAdrWidth-1:0] ramIdx [RamOps];

    accessT accQ [$];
    int     issuedCount  = 0;
    int     checkedCount = 0;
    int     passCount    = 0;
    int     failCount    = 0;
    int     testPass     = 0;
    int     testFail     = 0;
    int     cycleCount   = 0;
    integer seed         = 32'h7e0b;

    tbClock tbClock_i (
        .clk_o  (wbClk),
        .rstN_o (rstN)
    );

    fabIpTop fabIpTop_i (
        .wbClk_i   (wbClk),
        .rstN_i    (rstN),
        .wbReq_i   (wbReq),
        .wbRsp_o   (wbRsp),
        .gpioIn_i  (gpioIn),
        .gpioOut_o (gpioOut),
        .gpioOe_o  (gpioOe)
    );

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic isUnmapped(input adrT adr);
        logic [AdrWidth-RegionLsb-1:0] region;
        region = adr[AdrWidth-1:RegionLsb];
        return (region != 5'h00) && (region != 5'h01) && (region != 5'h08);
    endfunction

    function automatic wordT expectedRead(input adrT adr);
        logic [AdrWidth-RegionLsb-1:0] region;
        logic [6:0]                    ofs;
        wordT                          exp;
        region = adr[AdrWidth-1:RegionLsb];
        ofs    = adr[8:2];
        exp    = BadAccess;
        if (region == 5'h00)
        begin
            case (ofs)
                7'd0:    exp = DeviceIdValue;
                7'd1:    exp = RevLevel;
                7'd2:    exp = {24'h0, gpioIn};
                7'd3:    exp = {24'h0, gpioOutShadow};
                7'd4:    exp = {24'h0, gpioOeShadow};
                default: exp = RegDefault;
            endcase
        end
        else if (region == 5'h01)
            exp = (adr[11:10] == 2'b00) ? ramShadow[adr[9:2]] : RegDefault;
        else if (region == 5'h08)
        begin
            case (ofs)
                7'h7E:   exp = CustProdValue;
                7'h7F:   exp = RevisionsValue;
                default: exp = ResDefault;
            endcase
        end
        return exp;
    endfunction

    // Mapped blocks answer after one edge and the watchdog after Timeout + 1
    function automatic int expectedLatency(input adrT adr);
        return isUnmapped(adr) ? int'(WatchdogTimeout) + 1 : 1;
    endfunction

    // Model side effect of a write
    function automatic void applyWrite(input adrT adr, input selT sel, input wordT dat);
        if (adr[AdrWidth-1:RegionLsb] == 5'h00 && sel[0])
        begin
            if (adr[8:2] == 7'd3)
                gpioOutShadow = dat[7:0];
            if (adr[8:2] == 7'd4)
                gpioOeShadow = dat[7:0];
        end
        else if (adr[AdrWidth-1:RegionLsb] == 5'h01 && adr[11:10] == 2'b00)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (sel[lane])
                    ramShadow[adr[9:2]][8*lane +: 8] = dat[8*lane +: 8];
            end
        end
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic checkWord(input string name, input wordT exp, input wordT act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            failCount++;
        end
        else
            passCount++;
    endtask

    task automatic checkGpio(input string name, input gpioT exp, input gpioT act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            failCount++;
        end
        else
            passCount++;
    endtask

    task automatic checkAck(input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("CHECK FAILED wbRsp_o.ack: expected %h, got %h", exp, act);
            failCount++;
        end
        else
            passCount++;
    endtask

    task automatic checkLatency(input adrT adr, input int exp, input int act);
        if (act != exp)
        begin
            $display("CHECK FAILED wbRsp_o.ack latency @%h: expected %h, got %h",
                     adr, exp, act);
            failCount++;
        end
        else
            passCount++;
    endtask

    // --------------------------------------------------
    // Bus master
    // --------------------------------------------------
    task automatic busAccess(input adrT adr, input logic we, input selT sel, input wordT dat);
        accessT acc;
        int     lowCycles;
        @(negedge wbClk);
        wbReq = '{adr: adr, sel: sel, we: we, cyc: 1'b1, stb: 1'b1, dat: dat};
        lowCycles = 0;
        @(posedge wbClk);
        // Edges that sampled the request before ack
        while (!wbRsp.ack)
        begin
            lowCycles++;
            @(posedge wbClk);
        end
        acc = '{adr: adr, we: we, dat: wbRsp.dat, lat: lowCycles[15:0]};
        if (we)
            applyWrite(adr, sel, dat);
        accQ.push_back(acc);
        issuedCount++;
        @(negedge wbClk);
        wbReq.cyc = 1'b0;
        wbReq.stb = 1'b0;
        wbReq.we  = 1'b0;
    endtask

    task automatic busWrite(input adrT adr, input selT sel, input wordT dat);
        busAccess(adr, 1'b1, sel, dat);
    endtask

    task automatic busRead(input adrT adr);
        busAccess(adr, 1'b0, 4'hF, '0);
    endtask

    // Waits until every access is compared and reports the test
    task automatic finishTest(input string name);
        while (checkedCount != issuedCount)
            @(posedge wbClk);
        $display("%s: %0d checks, %0d failed", name,
                 passCount + failCount - testPass - testFail, failCount - testFail);
        testPass = passCount;
        testFail = failCount;
    endtask

    // --------------------------------------------------
    // Compare process
    // --------------------------------------------------
    always @(negedge wbClk)
    begin : compareProc
        accessT acc;
        while (accQ.size() > 0)
        begin
            acc = accQ.pop_front();
            if (!acc.we)
                checkWord($sformatf("wbRsp_o.dat @%h", acc.adr), expectedRead(acc.adr), acc.dat);
            checkLatency(acc.adr, expectedLatency(acc.adr), int'(acc.lat));
            checkGpio("gpioOut_o", gpioOutShadow, gpioOut);
            checkGpio("gpioOe_o", gpioOeShadow, gpioOe);
            checkedCount++;
        end
    end

    // Run limit
    initial
    begin : runLimit
        while (cycleCount < CycleLimit)
        begin
            @(posedge wbClk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
        $display("Regression failed");
        $finish;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial
    begin : stimulus
        wordT gpioWord;
        wordT fill;
        wbReq  = '0;
        gpioIn = '0;
        wait (rstN === 1'b1);
        @(negedge wbClk);
        checkGpio("gpioOut_o", 8'h00, gpioOut);
        checkGpio("gpioOe_o", 8'h00, gpioOe);
        checkAck(1'b0, wbRsp.ack);
        finishTest("reset state");

        busRead(RegBase + 17'h0);
        busRead(RegBase + 17'h4);
        busRead(ReservedBase + {8'h0, ResCustProdAdr, 2'b00});
        busRead(ReservedBase + {8'h0, ResRevisionsAdr, 2'b00});
        finishTest("identification");

        @(negedge wbClk);
        gpioIn   = gpioT'($random(seed));
        gpioWord = wordT'($random(seed));
        busWrite(RegBase + 17'hC, 4'hF, gpioWord);
        busWrite(RegBase + 17'h10, 4'hF, ~gpioWord);
        busRead(RegBase + 17'hC);
        busRead(RegBase + 17'h10);
        busRead(RegBase + 17'h8);
        // Lane 0 off so the pins must hold
        busWrite(RegBase + 17'hC, 4'b1110, gpioWord ^ 32'hFF);
        busRead(RegBase + 17'hC);
        finishTest("gpio");

        // Full-word fill so every later lane is known
        for (int i = 0; i < RamOps; i++)
        begin
            ramIdx[i] = RamAdrWidth'($random(seed));
            fill      = {~ramIdx[i], ramIdx[i] ^ 8'h5A, ramIdx[i], 8'hC3 ^ ramIdx[i]};
            busWrite(RamBase + {7'd0, ramIdx[i], 2'b00}, 4'hF, fill);
        end
        for (int i = 0; i < RamOps; i++)
            busWrite(RamBase + {7'd0, ramIdx[i], 2'b00}, selT'($random(seed)),
                     wordT'($random(seed)));
        for (int i = 0; i < RamOps; i++)
            busRead(RamBase + {7'd0, ramIdx[i], 2'b00});
        finishTest("ram");

        busRead(RegBase + 17'h40);
        busRead(RamBase + 17'h400);
        busRead(ReservedBase + 17'h0);
        finishTest("defaults");

        busRead(17'h10000);
        finishTest("unmapped");

        // Protocol assertion failures count as failed checks
        failCount += fabIpTop_i.fabIpChk_i.assertFails;
        $display("Summary: %0d checks passed, %0d failed", passCount, failCount);
        if (failCount == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: tb.f
logic/fabIpPkg.sv
logic/fabRegisters.sv
logic/fabRam.sv
logic/fabReserved.sv
logic/fabBusFabric.sv
logic/fabIpTop.sv
bench/tbClock.sv
bench/fabIp_chk.sv
bench/fabIpTb.sv

// File: Bender.yml
package:
  name: fab_ip

dependencies: {}

sources:
  # RTL, package first
  - logic/fabIpPkg.sv
  - logic/fabRegisters.sv
  - logic/fabRam.sv
  - logic/fabReserved.sv
  - logic/fabBusFabric.sv
  - logic/fabIpTop.sv

  # Testbench
  - target: test
    files:
      - bench/tbClock.sv
      - bench/fabIp_chk.sv
      - bench/fabIpTb.sv
